/* compile.f */
hdl/obi_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/obi_sram.sv
hdl/core_cntrl_regs.sv
hdl/instr_fetcher.sv
hdl/irq_merge.sv
hdl/dut_wrap.sv
tests/dut_wrap_tb.sv

/* tests/dut_wrap_tb.sv */
`timescale 1ns/1ps

module dut_wrap_tb
    import obi_pkg::*;
    import core_ctrl_pkg::*;
;

    // Several times the cycles that all tests need together
    localparam int CYCLE_LIMIT = 4000;

    logic     clk_i;
    logic     rst_n_i;
    obi_req_t data_req;
    obi_rsp_t data_rsp;
    irq_vec_t irq_a;
    irq_vec_t irq_b;
    logic     irq;
    irq_id_t  irq_id;
    logic     irq_ack;
    data_t    instr;
    addr_t    pc;
    logic     instr_valid;
    logic     instr_ready;

    // Expected memory contents, only written words are ever compared
    data_t       mem_model [RAM_WORDS];
    data_t       traffic_words [8];
    logic [15:0] lfsr_q;
    int          cycle_cnt;

    dut_wrap dut_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .data_req_i    (data_req),
        .data_rsp_o    (data_rsp),
        .irq_a_i       (irq_a),
        .irq_b_i       (irq_b),
        .irq_o         (irq),
        .irq_id_o      (irq_id),
        .irq_ack_i     (irq_ack),
        .instr_o       (instr),
        .pc_o          (pc),
        .instr_valid_o (instr_valid),
        .instr_ready_i (instr_ready)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Run limit
    always @(posedge clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: no progress after %0d cycles", cycle_cnt);
            $display("Testbench failed");
            $fatal(1, "Run stopped at the cycle limit");
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic data_t rand_word();
        data_t w;
        for (int i = 0; i < 32; i++) begin
            w[i] = lfsr_bit();
        end
        return w;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    // One data bus transfer: hold until gnt, then wait for rvalid
    task automatic bus_access(input logic we, input addr_t addr, input data_t wdata,
                              input be_t be, output data_t rdata);
        @(posedge clk_i);
        #2;
        data_req.req   = 1'b1;
        data_req.we    = we;
        data_req.be    = be;
        data_req.addr  = addr;
        data_req.wdata = wdata;
        @(negedge clk_i);
        while (!data_rsp.gnt) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #2;
        data_req = '0;
        @(negedge clk_i);
        while (!data_rsp.rvalid) begin
            @(negedge clk_i);
        end
        rdata = data_rsp.rdata;
    endtask

    task automatic bus_write(input addr_t addr, input data_t wdata, input be_t be);
        data_t unused;
        bus_access(1'b1, addr, wdata, be, unused);
    endtask

    task automatic bus_read(input addr_t addr, output data_t rdata);
        bus_access(1'b0, addr, '0, 4'hF, rdata);
    endtask

    // Write memory and keep the model in step, lane by lane
    task automatic mem_write(input addr_t addr, input data_t wdata, input be_t be);
        data_t lane_mask;
        lane_mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        bus_write(addr, wdata, be);
        mem_model[addr[RAM_AW+1:2]] = (mem_model[addr[RAM_AW+1:2]] & ~lane_mask) |
                                      (wdata & lane_mask);
    endtask

    task automatic mem_check(input addr_t addr);
        data_t rd;
        bus_read(addr, rd);
        check("data_rsp_o.rdata", rd, mem_model[addr[RAM_AW+1:2]]);
    endtask

    // Take n words from the stream with random ready gaps
    task automatic consume_stream(input addr_t boot, input int n);
        int got;
        got = 0;
        while (got < n) begin
            @(posedge clk_i);
            #2;
            instr_ready = lfsr_bit();
            @(negedge clk_i);
            if (instr_valid && instr_ready) begin
                check("pc_o", pc, boot + addr_t'(4 * got));
                check("instr_o", instr, mem_model[boot[RAM_AW+1:2] + ram_idx_t'(got)]);
                got++;
            end
        end
        @(posedge clk_i);
        #2;
        instr_ready = 1'b0;
    endtask

    task automatic start_fetch(input addr_t boot);
        bus_write(CTRL_BASE + 32'h0, boot, 4'hF);
        bus_write(CTRL_BASE + 32'h4, 32'h1, 4'hF);
    endtask

    // Disable with the stream stalled, then drain what is left
    task automatic stop_fetch();
        instr_ready = 1'b0;
        bus_write(CTRL_BASE + 32'h4, 32'h0, 4'hF);
        @(posedge clk_i);
        #2;
        instr_ready = 1'b1;
        repeat (8) @(posedge clk_i);
        #2;
        instr_ready = 1'b0;
        @(negedge clk_i);
        check("instr_valid_o", instr_valid, 1'b0);
    endtask

    task automatic ack_irq();
        @(posedge clk_i);
        #2;
        irq_ack = 1'b1;
        @(posedge clk_i);
        #2;
        irq_ack = 1'b0;
        @(negedge clk_i);
    endtask

    // ------------------------------
    // Tests
    // ------------------------------

    task automatic reset_values();
        data_t rd;
        @(negedge clk_i);
        check("instr_valid_o", instr_valid, 1'b0);
        check("irq_o", irq, 1'b0);
        bus_read(CTRL_BASE + 32'h0, rd);
        check("boot_addr", rd, 32'h0);
        bus_read(CTRL_BASE + 32'h4, rd);
        check("fetch_en", rd, 32'h0);
        bus_read(CTRL_BASE + 32'h8, rd);
        check("irq_mask", rd, 32'hFFFF_FFFF);
    endtask

    task automatic memory_readback();
        for (int k = 0; k < 8; k++) begin
            mem_write(addr_t'(32'h400 + 4 * k), rand_word(), 4'hF);
        end
        for (int k = 0; k < 8; k++) begin
            mem_check(addr_t'(32'h400 + 4 * k));
        end
        // Partial writes touch only the enabled lanes
        mem_write(32'h404, rand_word(), 4'b0101);
        mem_write(32'h408, rand_word(), 4'b1000);
        mem_check(32'h404);
        mem_check(32'h408);
    endtask

    task automatic stream_in_order();
        for (int k = 0; k < 16; k++) begin
            mem_write(addr_t'(32'h100 + 4 * k), rand_word(), 4'hF);
        end
        start_fetch(32'h100);
        consume_stream(32'h100, 16);
        stop_fetch();
    endtask

    task automatic data_traffic();
        for (int k = 0; k < 8; k++) begin
            mem_write(addr_t'(32'h800 + 4 * k), traffic_words[k], 4'hF);
            mem_check(addr_t'(32'h800 + 4 * k));
            // Reads from the region the fetcher is streaming
            mem_check(addr_t'(32'h200 + 4 * k));
            mem_check(addr_t'(32'h800 + 4 * (k / 2)));
        end
    endtask

    task automatic arbitration_mix();
        for (int k = 0; k < 16; k++) begin
            mem_write(addr_t'(32'h200 + 4 * k), rand_word(), 4'hF);
        end
        for (int k = 0; k < 8; k++) begin
            traffic_words[k] = rand_word();
        end
        start_fetch(32'h200);
        fork
            consume_stream(32'h200, 16);
            data_traffic();
        join
        stop_fetch();
    endtask

    task automatic irq_priority();
        irq_vec_t mask;
        irq_vec_t pend;
        int       top;
        mask = ~(irq_vec_t'(1) << 20);
        bus_write(CTRL_BASE + 32'h8, mask, 4'hF);
        @(posedge clk_i);
        #2;
        irq_a = (irq_vec_t'(1) << 3) | (irq_vec_t'(1) << 20) | (irq_vec_t'(1) << 9);
        irq_b = (irq_vec_t'(1) << 15) | (irq_vec_t'(1) << 27);
        pend  = irq_a | irq_b;
        // Pending shows up one edge later
        @(posedge clk_i);
        #2;
        @(negedge clk_i);
        while ((pend & mask) != '0) begin
            top = 0;
            for (int i = 0; i < 32; i++) begin
                if (pend[i] && mask[i]) begin
                    top = i;
                end
            end
            check("irq_o", irq, 1'b1);
            check("irq_id_o", irq_id, top);
            ack_irq();
            pend[top] = 1'b0;
        end
        check("irq_o", irq, 1'b0);
        // Line 20 stayed pending behind the mask
        bus_write(CTRL_BASE + 32'h8, 32'hFFFF_FFFF, 4'hF);
        @(negedge clk_i);
        check("irq_o", irq, 1'b1);
        check("irq_id_o", irq_id, 20);
        ack_irq();
        check("irq_o", irq, 1'b0);
        @(posedge clk_i);
        #2;
        irq_a = '0;
        irq_b = '0;
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        lfsr_q      = 16'd46976;
        cycle_cnt   = 0;
        rst_n_i     = 1'b0;
        data_req    = '0;
        irq_a       = '0;
        irq_b       = '0;
        irq_ack     = 1'b0;
        instr_ready = 1'b0;
        repeat (10) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        reset_values();
        memory_readback();
        stream_in_order();
        arbitration_mix();
        irq_priority();
        $display("Testbench passed");
        $finish;
    end

endmodule : dut_wrap_tb

/* hdl/dut_wrap.sv */
`timescale 1ns/1ps

module dut_wrap
    import obi_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    // Data bus, read and write with byte enables
    input  obi_req_t data_req_i,
    output obi_rsp_t data_rsp_o,
    // Interrupt sources and id/ack handshake
    input  irq_vec_t irq_a_i,
    input  irq_vec_t irq_b_i,
    output logic     irq_o,
    output irq_id_t  irq_id_o,
    input  logic     irq_ack_i,
    // Fetched instruction stream
    output data_t    instr_o,
    output addr_t    pc_o,
    output logic     instr_valid_o,
    input  logic     instr_ready_i
);

    // Fetcher to memory
    instr_req_t instr_req;
    obi_rsp_t   instr_rsp;
    // Register block to memory
    obi_req_t   mem_req;
    obi_rsp_t   mem_rsp;
    // Control steering
    addr_t      boot_addr;
    logic       fetch_en;
    irq_vec_t   irq_mask;

    // ------------------------------
    // Memory and data decode
    // ------------------------------

    obi_sram obi_sram_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .instr_req_i (instr_req),
        .instr_rsp_o (instr_rsp),
        .data_req_i  (mem_req),
        .data_rsp_o  (mem_rsp)
    );

    core_cntrl_regs core_cntrl_regs_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .bus_req_i   (data_req_i),
        .bus_rsp_o   (data_rsp_o),
        .mem_req_o   (mem_req),
        .mem_rsp_i   (mem_rsp),
        .boot_addr_o (boot_addr),
        .fetch_en_o  (fetch_en),
        .irq_mask_o  (irq_mask)
    );

    // ------------------------------
    // Fetch and interrupts
    // ------------------------------

    instr_fetcher instr_fetcher_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .boot_addr_i   (boot_addr),
        .fetch_en_i    (fetch_en),
        .mem_req_o     (instr_req),
        .mem_rsp_i     (instr_rsp),
        .instr_o       (instr_o),
        .pc_o          (pc_o),
        .instr_valid_o (instr_valid_o),
        .instr_ready_i (instr_ready_i)
    );

    irq_merge irq_merge_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .irq_a_i    (irq_a_i),
        .irq_b_i    (irq_b_i),
        .irq_mask_i (irq_mask),
        .irq_o      (irq_o),
        .irq_id_o   (irq_id_o),
        .irq_ack_i  (irq_ack_i)
    );

endmodule : dut_wrap

/* hdl/irq_merge.sv */
`timescale 1ns/1ps

module irq_merge
    import core_ctrl_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    // Two interrupt sources
    input  irq_vec_t irq_a_i,
    input  irq_vec_t irq_b_i,
    input  irq_vec_t irq_mask_i,
    // Core side
    output logic     irq_o,
    output irq_id_t  irq_id_o,
    input  logic     irq_ack_i
);

    irq_vec_t src;
    irq_vec_t src_q;
    irq_vec_t pend_q;
    irq_vec_t active;
    irq_vec_t clr;

    // ------------------------------
    // Merge and latch
    // ------------------------------

    assign src = irq_a_i | irq_b_i;

    // Line served by the current ack
    assign clr = irq_ack_i ? (irq_vec_t'(1) << irq_id_o) : '0;

    // Rising edges set pending, so a line still held high after ack stays cleared
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            src_q  <= '0;
            pend_q <= '0;
        end else begin
            src_q  <= src;
            pend_q <= (pend_q & ~clr) | (src & ~src_q);
        end
    end

    // ------------------------------
    // Mask and priority
    // ------------------------------

    assign active = pend_q & irq_mask_i;
    assign irq_o  = |active;

    // Highest index wins
    always_comb begin
        irq_id_o = '0;
        for (int i = 0; i < IRQ_NUM; i++) begin
            if (active[i]) begin
                irq_id_o = irq_id_t'(i);
            end
        end
    end

    // Core acks only a request it has seen
    a_ack_with_irq : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        irq_ack_i |-> irq_o);

endmodule : irq_merge

/* hdl/instr_fetcher.sv */
`timescale 1ns/1ps

module instr_fetcher
    import obi_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  addr_t      boot_addr_i,
    input  logic       fetch_en_i,
    // Instruction bus
    output instr_req_t mem_req_o,
    input  obi_rsp_t   mem_rsp_i,
    // Fetched word stream
    output data_t      instr_o,
    output addr_t      pc_o,
    output logic       instr_valid_o,
    input  logic       instr_ready_i
);

    // One buffered fetch result
    typedef struct packed {
        data_t word;
        addr_t pc;
    } fetch_ent_t;

    fetch_state_e               state_q;
    fetch_state_e               state_d;
    addr_t                      req_pc_q;
    addr_t                      rsp_pc_q;
    fetch_cnt_t                 inflight_q;
    fetch_cnt_t                 cnt_q;
    logic [$bits(fetch_cnt_t):0] occ;
    logic                       room;
    logic                       start;
    logic                       req_fire;
    logic                       push;
    logic                       pop;
    fetch_ent_t                 buf_q [FETCH_DEPTH];
    logic                       wr_ptr_q;
    logic                       rd_ptr_q;

    // ------------------------------
    // Request side
    // ------------------------------

    // Buffer slots are reserved at request time
    assign occ  = {1'b0, cnt_q} + {1'b0, inflight_q};
    assign room = (occ < FETCH_DEPTH);

    always_comb begin
        mem_req_o.req  = (state_q == RUN) && room;
        mem_req_o.addr = req_pc_q;
    end

    assign req_fire = mem_req_o.req & mem_rsp_i.gnt;
    assign push     = mem_rsp_i.rvalid;
    assign pop      = instr_valid_o & instr_ready_i;

    // Restart waits for old reads to drain so response PCs line up
    assign start = (state_q == IDLE) && fetch_en_i && (inflight_q == '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                // Never drop a request that is still waiting for gnt
                if (!fetch_en_i && (!mem_req_o.req || mem_rsp_i.gnt)) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            inflight_q <= '0;
            cnt_q      <= '0;
            wr_ptr_q   <= 1'b0;
            rd_ptr_q   <= 1'b0;
            req_pc_q   <= '0;
            rsp_pc_q   <= '0;
        end else begin
            state_q    <= state_d;
            inflight_q <= inflight_q + fetch_cnt_t'(req_fire) - fetch_cnt_t'(push);
            cnt_q      <= cnt_q + fetch_cnt_t'(push) - fetch_cnt_t'(pop);
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
                rsp_pc_q <= rsp_pc_q + addr_t'(4);
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            // Both PCs restart from the boot address
            if (start) begin
                req_pc_q <= boot_addr_i;
                rsp_pc_q <= boot_addr_i;
            end else if (req_fire) begin
                req_pc_q <= req_pc_q + addr_t'(4);
            end
        end
    end

    // ------------------------------
    // Output buffer
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (push) begin
            buf_q[wr_ptr_q] <= '{word: mem_rsp_i.rdata, pc: rsp_pc_q};
        end
    end

    assign instr_valid_o = (cnt_q != '0);
    assign instr_o       = buf_q[rd_ptr_q].word;
    assign pc_o          = buf_q[rd_ptr_q].pc;

    // Slots held across request, response and stream never overflow
    a_occ_max : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        occ <= FETCH_DEPTH);

endmodule : instr_fetcher

/* hdl/core_cntrl_regs.sv */
`timescale 1ns/1ps

module core_cntrl_regs
    import obi_pkg::*;
    import core_ctrl_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    // External data bus
    input  obi_req_t bus_req_i,
    output obi_rsp_t bus_rsp_o,
    // Everything outside the register window
    output obi_req_t mem_req_o,
    input  obi_rsp_t mem_rsp_i,
    // Steering for fetcher and interrupt block
    output addr_t    boot_addr_o,
    output logic     fetch_en_o,
    output irq_vec_t irq_mask_o
);

    logic     sel_reg;
    logic     reg_acc;
    reg_ofs_t reg_ofs;
    data_t    reg_rdata;
    data_t    reg_rdata_q;
    logic     reg_rvalid_q;
    addr_t    boot_addr_q;
    logic     fetch_en_q;
    irq_vec_t irq_mask_q;

    // Merge write data into a register per byte lane
    function automatic data_t be_merge(data_t old_val, data_t new_val, be_t be);
        data_t res;
        res = old_val;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    // ------------------------------
    // Address decode
    // ------------------------------

    assign sel_reg = (bus_req_i.addr[ADDR_W-1:CTRL_WIN_W] == CTRL_BASE[ADDR_W-1:CTRL_WIN_W]);
    assign reg_ofs = bus_req_i.addr[CTRL_WIN_W-1:2];
    assign reg_acc = bus_req_i.req & sel_reg;

    // Pass through unchanged, request masked off for register hits
    always_comb begin
        mem_req_o     = bus_req_i;
        mem_req_o.req = bus_req_i.req & ~sel_reg;
    end

    // Read mux, unmapped offsets read zero
    always_comb begin
        case (reg_ofs)
            REG_BOOT_ADDR: reg_rdata = boot_addr_q;
            REG_FETCH_EN:  reg_rdata = data_t'(fetch_en_q);
            REG_IRQ_MASK:  reg_rdata = irq_mask_q;
            default:       reg_rdata = '0;
        endcase
    end

    // ------------------------------
    // Registers
    // ------------------------------

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            boot_addr_q  <= '0;
            fetch_en_q   <= 1'b0;
            irq_mask_q   <= '1;
            reg_rvalid_q <= 1'b0;
        end else begin
            reg_rvalid_q <= reg_acc;
            if (reg_acc && bus_req_i.we) begin
                case (reg_ofs)
                    REG_BOOT_ADDR: boot_addr_q <= be_merge(boot_addr_q, bus_req_i.wdata,
                                                           bus_req_i.be);
                    REG_FETCH_EN: begin
                        if (bus_req_i.be[0]) begin
                            fetch_en_q <= bus_req_i.wdata[0];
                        end
                    end
                    REG_IRQ_MASK:  irq_mask_q <= be_merge(irq_mask_q, bus_req_i.wdata,
                                                          bus_req_i.be);
                    default: ;
                endcase
            end
        end
    end

    // Read data sampled at grant
    always_ff @(posedge clk_i) begin
        if (reg_acc) begin
            reg_rdata_q <= reg_rdata;
        end
    end

    assign boot_addr_o = boot_addr_q;
    assign fetch_en_o  = fetch_en_q;
    assign irq_mask_o  = irq_mask_q;

    // ------------------------------
    // Response
    // ------------------------------

    // Both targets answer one cycle after grant, never in the same cycle
    always_comb begin
        bus_rsp_o.gnt    = sel_reg ? bus_req_i.req : mem_rsp_i.gnt;
        bus_rsp_o.rvalid = reg_rvalid_q | mem_rsp_i.rvalid;
        bus_rsp_o.rdata  = reg_rvalid_q ? reg_rdata_q : mem_rsp_i.rdata;
    end

    // Memory only answers what was forwarded to it the cycle before
    a_mem_rvalid_fwd : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_rsp_i.rvalid |-> $past(mem_req_o.req && mem_rsp_i.gnt));

endmodule : core_cntrl_regs

/* hdl/obi_sram.sv */
`timescale 1ns/1ps

module obi_sram
    import obi_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    // Instruction port, read only
    input  instr_req_t instr_req_i,
    output obi_rsp_t   instr_rsp_o,
    // Data port, read and write
    input  obi_req_t   data_req_i,
    output obi_rsp_t   data_rsp_o
);

    data_t    mem_q [RAM_WORDS];
    data_t    rdata_q;
    ram_idx_t ram_idx;
    logic     data_gnt;
    logic     instr_gnt;
    logic     data_rvalid_q;
    logic     instr_rvalid_q;

    // ------------------------------
    // Arbiter
    // ------------------------------

    // Data port always wins
    assign data_gnt  = data_req_i.req;
    // Fetch only gets the array in idle data cycles
    assign instr_gnt = instr_req_i.req & ~data_req_i.req;

    // Word index from the granted port
    assign ram_idx = data_gnt ? data_req_i.addr[RAM_AW+1:2] : instr_req_i.addr[RAM_AW+1:2];

    // ------------------------------
    // Array
    // ------------------------------

    always_ff @(posedge clk_i) begin
        // Byte lane writes
        if (data_gnt && data_req_i.we) begin
            for (int b = 0; b < BE_W; b++) begin
                if (data_req_i.be[b]) begin
                    mem_q[ram_idx][8*b +: 8] <= data_req_i.wdata[8*b +: 8];
                end
            end
        end
        // One read port shared by both requesters
        if (instr_gnt || (data_gnt && !data_req_i.we)) begin
            rdata_q <= mem_q[ram_idx];
        end
    end

    // Response flags follow last cycle's grant
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_rvalid_q  <= 1'b0;
            instr_rvalid_q <= 1'b0;
        end else begin
            data_rvalid_q  <= data_gnt;
            instr_rvalid_q <= instr_gnt;
        end
    end

    assign data_rsp_o.gnt     = data_gnt;
    assign data_rsp_o.rvalid  = data_rvalid_q;
    assign data_rsp_o.rdata   = rdata_q;

    assign instr_rsp_o.gnt    = instr_gnt;
    assign instr_rsp_o.rvalid = instr_rvalid_q;
    assign instr_rsp_o.rdata  = rdata_q;

    // A stalled fetch keeps asking for the same word until the array is free
    a_instr_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (instr_req_i.req && !instr_rsp_o.gnt) |=>
            (instr_req_i.req && $stable(instr_req_i.addr)));

endmodule : obi_sram

/* hdl/core_ctrl_pkg.sv */
package core_ctrl_pkg;

    // ------------------------------
    // Interrupts
    // ------------------------------

    localparam int IRQ_NUM  = 32;
    localparam int IRQ_ID_W = $clog2(IRQ_NUM);

    typedef logic [IRQ_NUM-1:0]  irq_vec_t;
    typedef logic [IRQ_ID_W-1:0] irq_id_t;

    // ------------------------------
    // Control register map
    // ------------------------------

    localparam logic [31:0] CTRL_BASE = 32'h1000_0000;
    // Address bits below this select inside the register window
    localparam int CTRL_WIN_W = 12;

    // Word offset inside the window
    typedef logic [CTRL_WIN_W-3:0] reg_ofs_t;

    localparam reg_ofs_t REG_BOOT_ADDR = reg_ofs_t'(0);
    localparam reg_ofs_t REG_FETCH_EN  = reg_ofs_t'(1);
    localparam reg_ofs_t REG_IRQ_MASK  = reg_ofs_t'(2);

    // ------------------------------
    // Fetch unit
    // ------------------------------

    // Buffered words plus reads in flight
    localparam int FETCH_DEPTH = 2;
    typedef logic [$clog2(FETCH_DEPTH+1)-1:0] fetch_cnt_t;

    typedef enum logic {
        IDLE,
        RUN
    } fetch_state_e;

endpackage : core_ctrl_pkg

/* hdl/obi_pkg.sv */
package obi_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    // One enable per byte lane
    localparam int BE_W   = DATA_W / 8;

    // Shared memory size in words
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [BE_W-1:0]   be_t;
    // Word index into the memory array
    typedef logic [RAM_AW-1:0] ram_idx_t;

    // ------------------------------
    // OBI request and response
    // ------------------------------

    // Requester side, fields held until gnt
    typedef struct packed {
        logic  req;
        logic  we;
        be_t   be;
        addr_t addr;
        data_t wdata;
    } obi_req_t;

    // Target side, one rvalid per granted request
    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        data_t rdata;
    } obi_rsp_t;

    // Fetch requests are read only
    typedef struct packed {
        logic  req;
        addr_t addr;
    } instr_req_t;

endpackage : obi_pkg
